// ==== rtl/coherence_pkg.sv ====
/* Shared types for the MESI coherence fabric: CPU, snoop and L2 handshake structs,
   FSM and opcode enums, and bus width constants. */
package coherence_pkg;

    localparam int WORD_W          = 32;
    localparam int ADDR_W          = 32;
    localparam int MAX_BLOCK_WORDS = 4;   // BLOCK_WORDS must stay at or below this

    typedef logic [MAX_BLOCK_WORDS-1:0][WORD_W-1:0] block_t;

    typedef enum logic [1:0] {OP_RD, OP_RDX, OP_UPGR, OP_EVICT} bus_op_t;

    typedef enum logic [1:0] {M, E, S, I} mesi_t;

    typedef enum logic [3:0] {
        IDLE, GRANT_R, GRANT_RX, GRANT_INV, GRANT_EVICT,
        SNOOP_R, SNOOP_RX, SNOOP_INV, TRANSFER_R, TRANSFER_RX,
        READ_L2, WRITEBACK_MS, WRITEBACK, BUS_TO_CACHE, INVALIDATE
    } bus_state_t;

    typedef enum logic [1:0] {L2_FREE, L2_BUSY, L2_ACCESS} l2_state_t;

    typedef struct packed {
        logic              valid;
        bus_op_t           op;
        logic [ADDR_W-1:0] addr;
        block_t            data;    // store block for RDX, UPGR and EVICT
    } cpu_req_t;

    typedef struct packed {
        logic   dwait;              // low for one cycle on completion
        block_t load;
        logic   exclusive;
    } cpu_resp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // block aligned
        logic              inv;
        logic              ccwait;  // snoop active for this agent
    } snoop_req_t;

    typedef struct packed {
        logic   done;
        logic   hit;
        logic   dirty;
        logic   present;
        block_t data;
    } snoop_resp_t;

    typedef struct packed {
        logic              ren;
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] store;
    } l2_req_t;

    typedef struct packed {
        l2_state_t         state;
        logic [WORD_W-1:0] load;
    } l2_resp_t;

    // clear the byte offset within a block of the given word count
    function automatic logic [ADDR_W-1:0] block_base(input logic [ADDR_W-1:0] addr,
                                                     input int words);
        return addr & ~ADDR_W'(words * 4 - 1);
    endfunction

endpackage

// ==== rtl/l2_mem.sv ====
/* Behavioral word-wide L2. A request is BUSY for L2_LATENCY cycles, then ACCESS
   for one cycle with the read word, then FREE once the enable drops. */
`timescale 1ns/1ps

module l2_mem #(
    parameter int L2_LATENCY  = 2,
    parameter int DEPTH_WORDS = 1024
)(
    input  logic                    CLK,
    input  logic                    nRST,
    input  coherence_pkg::l2_req_t  l2_req,
    output coherence_pkg::l2_resp_t l2_resp
);
    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int LAT_W = $clog2(L2_LATENCY + 1);

    logic [coherence_pkg::WORD_W-1:0] mem [DEPTH_WORDS];
    logic [coherence_pkg::WORD_W-1:0] rdata;
    coherence_pkg::l2_state_t         state;
    logic [LAT_W-1:0]                 lat_cnt;
    logic [IDX_W-1:0]                 idx;
    logic                             en;

    assign idx = l2_req.addr[IDX_W+1:2];   // byte address to word index
    assign en  = l2_req.ren || l2_req.wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH_WORDS; i++)
                mem[i] <= '0;
            rdata   <= '0;
            lat_cnt <= '0;
            state   <= coherence_pkg::L2_FREE;
        end else begin
            case (state)
                coherence_pkg::L2_FREE: if (en) begin
                    state   <= coherence_pkg::L2_BUSY;
                    lat_cnt <= LAT_W'(L2_LATENCY - 1);
                end
                coherence_pkg::L2_BUSY: begin
                    if (lat_cnt == '0) begin
                        state <= coherence_pkg::L2_ACCESS;
                        rdata <= mem[idx];
                        if (l2_req.wen)
                            mem[idx] <= l2_req.store;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                default: if (!en) state <= coherence_pkg::L2_FREE;
            endcase
        end
    end

    assign l2_resp.state = state;
    assign l2_resp.load  = rdata;

endmodule

// ==== rtl/snoop_agent.sv ====
/* Per-CPU snoop agent. Keeps a fully associative MESI directory with line data,
   answers bus snoops and installs its own CPU's completed transactions. */
`timescale 1ns/1ps

module snoop_agent #(
    parameter int BLOCK_WORDS = 2,
    parameter int DIR_LINES   = 4
)(
    input  logic                       CLK,
    input  logic                       nRST,
    input  coherence_pkg::cpu_req_t    req,
    input  coherence_pkg::cpu_resp_t   resp,
    input  coherence_pkg::snoop_req_t  snp_req,
    output coherence_pkg::snoop_resp_t snp_resp
);
    localparam int IDX_W = (DIR_LINES > 1) ? $clog2(DIR_LINES) : 1;

    logic [coherence_pkg::ADDR_W-1:0] tag  [DIR_LINES];   // block address
    coherence_pkg::block_t            line [DIR_LINES];
    coherence_pkg::mesi_t             mesi [DIR_LINES];
    logic [IDX_W-1:0]                 fill_ptr;           // round-robin victim

    logic             snp_hit, own_hit;
    logic [IDX_W-1:0] snp_idx, own_idx, slot;
    logic             install;

    always_comb begin
        snp_hit = 1'b0;
        snp_idx = '0;
        own_hit = 1'b0;
        own_idx = '0;
        for (int i = 0; i < DIR_LINES; i++) begin
            if (mesi[i] != coherence_pkg::I && tag[i] == snp_req.addr) begin
                snp_hit = 1'b1;
                snp_idx = IDX_W'(i);
            end
            if (mesi[i] != coherence_pkg::I &&
                tag[i] == coherence_pkg::block_base(req.addr, BLOCK_WORDS)) begin
                own_hit = 1'b1;
                own_idx = IDX_W'(i);
            end
        end
    end

    assign install = req.valid && !resp.dwait;   // completion cycle of own request
    assign slot    = own_hit ? own_idx : fill_ptr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DIR_LINES; i++)
                mesi[i] <= coherence_pkg::I;
            fill_ptr <= '0;
            snp_resp <= '0;
        end else begin
            snp_resp.done <= snp_req.ccwait;
            if (snp_req.ccwait && !snp_resp.done) begin    // first snoop cycle
                snp_resp.hit     <= snp_hit;               // any valid copy can supply
                snp_resp.present <= snp_hit;
                snp_resp.dirty   <= snp_hit && mesi[snp_idx] == coherence_pkg::M;
                snp_resp.data    <= line[snp_idx];
                if (snp_hit && snp_req.inv)
                    mesi[snp_idx] <= coherence_pkg::I;
                else if (snp_hit && mesi[snp_idx] inside {coherence_pkg::M, coherence_pkg::E})
                    mesi[snp_idx] <= coherence_pkg::S;    // another reader now shares
            end
            if (install) begin
                case (req.op)
                    coherence_pkg::OP_RD:
                        mesi[slot] <= resp.exclusive ? coherence_pkg::E : coherence_pkg::S;
                    coherence_pkg::OP_RDX, coherence_pkg::OP_UPGR:
                        mesi[slot] <= coherence_pkg::M;
                    default:
                        if (own_hit) mesi[own_idx] <= coherence_pkg::I;
                endcase
                if (!own_hit && req.op != coherence_pkg::OP_EVICT)
                    fill_ptr <= (fill_ptr == IDX_W'(DIR_LINES - 1)) ? '0 : fill_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (install && req.op != coherence_pkg::OP_EVICT) begin
            tag[slot]  <= coherence_pkg::block_base(req.addr, BLOCK_WORDS);
            line[slot] <= (req.op == coherence_pkg::OP_RD) ? resp.load : req.data;
        end
    end

endmodule

// ==== rtl/bus_ctrl.sv ====
/* Coherence bus controller. Arbitrates CPU requests in IDLE, snoops the other
   caches and moves blocks cache to cache or between caches and the L2. */
`timescale 1ns/1ps

module bus_ctrl #(
    parameter int BLOCK_WORDS = 2,
    parameter int CPUS        = 2
)(
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  coherence_pkg::cpu_req_t    [CPUS-1:0] req,
    output coherence_pkg::cpu_resp_t   [CPUS-1:0] resp,
    output coherence_pkg::snoop_req_t  [CPUS-1:0] snp_req,
    input  coherence_pkg::snoop_resp_t [CPUS-1:0] snp_resp,
    output coherence_pkg::l2_req_t               l2_req,
    input  coherence_pkg::l2_resp_t              l2_resp
);
    localparam int ID_W  = (CPUS > 1) ? $clog2(CPUS) : 1;
    localparam int CNT_W = $clog2(coherence_pkg::MAX_BLOCK_WORDS);

    coherence_pkg::bus_state_t state, nstate;
    logic [ID_W-1:0]  req_id, nreq_id;
    logic [ID_W-1:0]  sup_id, nsup_id;
    logic             excl, nexcl;     // no other cache held the line
    logic [CNT_W-1:0] cnt, ncnt;       // word within the block
    coherence_pkg::block_t blk, nblk;
    logic [coherence_pkg::ADDR_W-1:0] l2_addr, nl2_addr;
    logic [coherence_pkg::ADDR_W-1:0] base;

    logic [CPUS-1:0] evict_v, rdx_v, rd_v, upgr_v;
    logic [CPUS-1:0] done_v, hit_v, present_v;
    logic [CPUS-1:0] others;
    logic            snoop_done, l2_acc, last_word;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state  <= coherence_pkg::IDLE;
            req_id <= '0;
            sup_id <= '0;
            excl   <= 1'b0;
            cnt    <= '0;
        end else begin
            state  <= nstate;
            req_id <= nreq_id;
            sup_id <= nsup_id;
            excl   <= nexcl;
            cnt    <= ncnt;
        end
    end

    always_ff @(posedge CLK) begin
        blk     <= nblk;
        l2_addr <= nl2_addr;
    end

    // per-class request vectors and snoop answers
    always_comb begin
        for (int i = 0; i < CPUS; i++) begin
            evict_v[i]   = req[i].valid && req[i].op == coherence_pkg::OP_EVICT;
            rdx_v[i]     = req[i].valid && req[i].op == coherence_pkg::OP_RDX;
            rd_v[i]      = req[i].valid && req[i].op == coherence_pkg::OP_RD;
            upgr_v[i]    = req[i].valid && req[i].op == coherence_pkg::OP_UPGR;
            done_v[i]    = snp_resp[i].done;
            hit_v[i]     = snp_resp[i].hit;
            present_v[i] = snp_resp[i].present;
        end
    end

    assign others     = ~(CPUS'(1) << req_id);
    assign base       = coherence_pkg::block_base(req[req_id].addr, BLOCK_WORDS);
    assign snoop_done = &(done_v | ~others);
    assign l2_acc     = l2_resp.state == coherence_pkg::L2_ACCESS;
    assign last_word  = cnt == CNT_W'(BLOCK_WORDS - 1);

    always_comb begin
        nstate   = state;
        nreq_id  = req_id;
        nsup_id  = sup_id;
        nexcl    = excl;
        ncnt     = cnt;
        nblk     = blk;
        nl2_addr = l2_addr;
        for (int i = 0; i < CPUS; i++) begin
            resp[i].dwait     = 1'b1;
            resp[i].load      = blk;
            resp[i].exclusive = 1'b0;
            snp_req[i].addr   = base;
            snp_req[i].inv    = 1'b0;
            snp_req[i].ccwait = 1'b0;
        end
        l2_req.ren   = 1'b0;
        l2_req.wen   = 1'b0;
        l2_req.addr  = l2_addr;
        l2_req.store = blk[cnt];

        case (state)
            coherence_pkg::IDLE: begin   // evict > rdx > rd > upgrade
                if (|evict_v) begin
                    nreq_id = pick(evict_v);
                    nstate  = coherence_pkg::GRANT_EVICT;
                end else if (|rdx_v) begin
                    nreq_id = pick(rdx_v);
                    nstate  = coherence_pkg::GRANT_RX;
                end else if (|rd_v) begin
                    nreq_id = pick(rd_v);
                    nstate  = coherence_pkg::GRANT_R;
                end else if (|upgr_v) begin
                    nreq_id = pick(upgr_v);
                    nstate  = coherence_pkg::GRANT_INV;
                end
            end
            coherence_pkg::GRANT_R, coherence_pkg::GRANT_RX, coherence_pkg::GRANT_INV: begin
                set_snoop(state != coherence_pkg::GRANT_R);
                nstate = (state == coherence_pkg::GRANT_R)  ? coherence_pkg::SNOOP_R :
                         (state == coherence_pkg::GRANT_RX) ? coherence_pkg::SNOOP_RX :
                                                              coherence_pkg::SNOOP_INV;
            end
            coherence_pkg::GRANT_EVICT: begin
                nblk     = req[req_id].data;
                nl2_addr = base;
                ncnt     = '0;
                nstate   = coherence_pkg::WRITEBACK;
            end
            coherence_pkg::SNOOP_R, coherence_pkg::SNOOP_RX: begin
                set_snoop(state == coherence_pkg::SNOOP_RX);
                if (snoop_done) begin
                    nexcl    = !(|(present_v & others));
                    nsup_id  = pick(hit_v & others);
                    nblk     = snp_resp[pick(hit_v & others)].data;  // supplier block
                    nl2_addr = base;
                    ncnt     = '0;
                    if (|(hit_v & others))
                        nstate = (state == coherence_pkg::SNOOP_R) ? coherence_pkg::TRANSFER_R
                                                                   : coherence_pkg::TRANSFER_RX;
                    else
                        nstate = coherence_pkg::READ_L2;
                end
            end
            coherence_pkg::SNOOP_INV: begin
                set_snoop(1'b1);
                if (snoop_done)
                    nstate = coherence_pkg::INVALIDATE;
            end
            coherence_pkg::TRANSFER_R: begin
                set_snoop(1'b0);
                nstate = snp_resp[sup_id].dirty ? coherence_pkg::WRITEBACK_MS
                                                : coherence_pkg::BUS_TO_CACHE;
            end
            coherence_pkg::TRANSFER_RX: begin
                set_snoop(1'b1);
                nstate = coherence_pkg::BUS_TO_CACHE;
            end
            coherence_pkg::READ_L2, coherence_pkg::WRITEBACK_MS, coherence_pkg::WRITEBACK: begin
                if (state == coherence_pkg::WRITEBACK_MS)
                    set_snoop(1'b0);        // keep the supplier parked
                l2_req.ren = (state == coherence_pkg::READ_L2) && !l2_acc;
                l2_req.wen = (state != coherence_pkg::READ_L2) && !l2_acc;
                if (l2_acc) begin
                    if (state == coherence_pkg::READ_L2)
                        nblk[cnt] = l2_resp.load;
                    ncnt     = cnt + 1'b1;
                    nl2_addr = l2_addr + 4;
                    if (last_word)
                        nstate = coherence_pkg::BUS_TO_CACHE;
                end
            end
            coherence_pkg::BUS_TO_CACHE: begin
                resp[req_id].dwait     = 1'b0;
                resp[req_id].exclusive = excl;
                nstate                 = coherence_pkg::IDLE;
            end
            coherence_pkg::INVALIDATE: begin
                resp[req_id].dwait = 1'b0;
                nstate             = coherence_pkg::IDLE;
            end
            default: nstate = coherence_pkg::IDLE;
        endcase
    end

    // highest numbered cpu wins
    function automatic logic [ID_W-1:0] pick(input logic [CPUS-1:0] v);
        logic [ID_W-1:0] id;
        id = '0;
        for (int i = 0; i < CPUS; i++) begin
            if (v[i])
                id = ID_W'(i);
        end
        return id;
    endfunction

    // snoop every agent except the requester
    function automatic void set_snoop(input logic inv);
        for (int i = 0; i < CPUS; i++) begin
            snp_req[i].ccwait = others[i];
            snp_req[i].inv    = inv && others[i];
        end
    endfunction

endmodule

// ==== rtl/coherence_top.sv ====
/* Top of the coherence fabric. Connects the bus controller, one snoop agent
   per CPU port and the L2 model. */
`timescale 1ns/1ps

module coherence_top #(
    parameter int BLOCK_WORDS = 2,
    parameter int CPUS        = 2,
    parameter int DIR_LINES   = 4,
    parameter int L2_LATENCY  = 2
)(
    input  logic                               CLK,
    input  logic                               nRST,
    input  coherence_pkg::cpu_req_t  [CPUS-1:0] req,
    output coherence_pkg::cpu_resp_t [CPUS-1:0] resp
);
    coherence_pkg::snoop_req_t  [CPUS-1:0] snp_req;
    coherence_pkg::snoop_resp_t [CPUS-1:0] snp_resp;
    coherence_pkg::l2_req_t                l2_req;
    coherence_pkg::l2_resp_t               l2_resp;

    bus_ctrl #(.BLOCK_WORDS(BLOCK_WORDS), .CPUS(CPUS)) u_bus_ctrl (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (req),
        .resp     (resp),
        .snp_req  (snp_req),
        .snp_resp (snp_resp),
        .l2_req   (l2_req),
        .l2_resp  (l2_resp)
    );

    for (genvar c = 0; c < CPUS; c++) begin : g_agent
        snoop_agent #(.BLOCK_WORDS(BLOCK_WORDS), .DIR_LINES(DIR_LINES)) u_agent (
            .CLK      (CLK),
            .nRST     (nRST),
            .req      (req[c]),
            .resp     (resp[c]),
            .snp_req  (snp_req[c]),
            .snp_resp (snp_resp[c])
        );
    end

    l2_mem #(.L2_LATENCY(L2_LATENCY), .DEPTH_WORDS(1024)) u_l2 (   // 4 KB of words
        .CLK     (CLK),
        .nRST    (nRST),
        .l2_req  (l2_req),
        .l2_resp (l2_resp)
    );

endmodule

// ==== verif/coherence_sva.sv ====
/* Concurrent checks on the bus controller handshakes, bound into every bus_ctrl. */
`timescale 1ns/1ps

module coherence_sva #(
    parameter int CPUS = 2,
    parameter int ID_W = 1
)(
    input logic                                 CLK,
    input logic                                 nRST,
    input coherence_pkg::bus_state_t            state,
    input logic [ID_W-1:0]                      req_id,
    input coherence_pkg::cpu_resp_t  [CPUS-1:0] resp,
    input coherence_pkg::snoop_req_t [CPUS-1:0] snp_req,
    input coherence_pkg::l2_req_t               l2_req
);
    logic [CPUS-1:0] wait_low;

    always_comb begin
        for (int i = 0; i < CPUS; i++)
            wait_low[i] = !resp[i].dwait;
    end

    a_one_wait_low: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(wait_low))
        else $error("more than one CPU sees wait low");

    a_no_l2_in_idle: assert property (@(posedge CLK) disable iff (!nRST)
        state == coherence_pkg::IDLE |-> !(l2_req.ren || l2_req.wen))
        else $error("L2 enable raised in IDLE");

    a_no_self_inv: assert property (@(posedge CLK) disable iff (!nRST) !snp_req[req_id].inv)
        else $error("invalidate sent to the requesting CPU");

endmodule

bind bus_ctrl coherence_sva #(.CPUS(CPUS), .ID_W(ID_W)) i_sva (
    .CLK     (CLK),
    .nRST    (nRST),
    .state   (state),
    .req_id  (req_id),
    .resp    (resp),
    .snp_req (snp_req),
    .l2_req  (l2_req)
);

// ==== verif/coherence_tb.sv ====
/* Testbench for coherence_top. Applies a table of CPU requests, predicts load data
   with a MESI and memory model, and checks data, exclusive flag, completion order
   and the final L2 contents. */
`timescale 1ns/1ps

module coherence_tb;
    localparam int CPUS        = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int DIR_LINES   = 8;
    localparam int L2_LATENCY  = 2;
    localparam int NLINES      = 8;    // model lines, index from addr[10:8]
    localparam int NSTEPS      = 19;
    localparam int TIMEOUT     = 200;  // cycles per batch

    typedef struct packed {
        logic [1:0]             cpu;
        coherence_pkg::bus_op_t op;
        logic [11:0]            addr;
        logic                   grp;   // issued together with its neighbours
        logic                   excl;  // expected exclusive flag on RD and RDX
        logic [1:0]             ord;   // expected completion position in the batch
    } step_t;

    step_t steps [NSTEPS] = '{
        '{2'd0, coherence_pkg::OP_RD,    12'h100, 1'b0, 1'b1, 2'd0},  // miss to L2
        '{2'd1, coherence_pkg::OP_RD,    12'h100, 1'b0, 1'b0, 2'd0},  // clean c2c
        '{2'd2, coherence_pkg::OP_RDX,   12'h200, 1'b0, 1'b1, 2'd0},
        '{2'd1, coherence_pkg::OP_RD,    12'h200, 1'b0, 1'b0, 2'd0},  // dirty c2c
        '{2'd0, coherence_pkg::OP_RD,    12'h200, 1'b0, 1'b0, 2'd0},
        '{2'd3, coherence_pkg::OP_RDX,   12'h200, 1'b0, 1'b0, 2'd0},  // kills three sharers
        '{2'd1, coherence_pkg::OP_RD,    12'h200, 1'b0, 1'b0, 2'd0},
        '{2'd2, coherence_pkg::OP_RDX,   12'h300, 1'b0, 1'b1, 2'd0},
        '{2'd2, coherence_pkg::OP_EVICT, 12'h300, 1'b0, 1'b0, 2'd0},
        '{2'd0, coherence_pkg::OP_RD,    12'h300, 1'b0, 1'b1, 2'd0},  // evicted block from L2
        '{2'd3, coherence_pkg::OP_UPGR,  12'h200, 1'b0, 1'b0, 2'd0},
        '{2'd0, coherence_pkg::OP_RD,    12'h200, 1'b0, 1'b0, 2'd0},
        '{2'd3, coherence_pkg::OP_RDX,   12'h400, 1'b0, 1'b1, 2'd0},
        '{2'd0, coherence_pkg::OP_UPGR,  12'h200, 1'b1, 1'b0, 2'd3},  // simultaneous batch
        '{2'd1, coherence_pkg::OP_RD,    12'h500, 1'b1, 1'b1, 2'd2},
        '{2'd2, coherence_pkg::OP_RDX,   12'h100, 1'b1, 1'b0, 2'd1},
        '{2'd3, coherence_pkg::OP_EVICT, 12'h400, 1'b1, 1'b0, 2'd0},
        '{2'd3, coherence_pkg::OP_RD,    12'h400, 1'b0, 1'b1, 2'd0},
        '{2'd1, coherence_pkg::OP_RD,    12'h100, 1'b0, 1'b0, 2'd0}
    };

    logic CLK;
    logic nRST;
    coherence_pkg::cpu_req_t  [CPUS-1:0] req;
    coherence_pkg::cpu_resp_t [CPUS-1:0] resp;

    coherence_pkg::mesi_t  st      [CPUS][NLINES];   // model cache states
    coherence_pkg::block_t dat     [CPUS][NLINES];
    coherence_pkg::block_t mem_img [NLINES];
    coherence_pkg::block_t store_q [NSTEPS];
    int checks, value_errs, order_errs, timeouts;

    coherence_top #(.BLOCK_WORDS(BLOCK_WORDS), .CPUS(CPUS), .DIR_LINES(DIR_LINES),
                    .L2_LATENCY(L2_LATENCY)) i_coherence_top (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (req),
        .resp (resp)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // apply the MESI rules to the model and return the block the requester should load
    task automatic predict_completion(input int c, input coherence_pkg::bus_op_t op,
                                      input int ln, input coherence_pkg::block_t store,
                                      output coherence_pkg::block_t load);
        int sup;
        sup = -1;
        for (int k = 0; k < CPUS; k++)
            if (k != c && st[k][ln] != coherence_pkg::I)
                sup = k;                                 // highest holder supplies
        load = (sup >= 0) ? dat[sup][ln] : mem_img[ln];
        case (op)
            coherence_pkg::OP_RD: begin
                if (sup >= 0 && st[sup][ln] == coherence_pkg::M)
                    mem_img[ln] = dat[sup][ln];          // shared read writes back
                for (int k = 0; k < CPUS; k++)
                    if (k != c && st[k][ln] inside {coherence_pkg::M, coherence_pkg::E})
                        st[k][ln] = coherence_pkg::S;
                st[c][ln]  = (sup >= 0) ? coherence_pkg::S : coherence_pkg::E;
                dat[c][ln] = load;
            end
            coherence_pkg::OP_RDX, coherence_pkg::OP_UPGR: begin
                for (int k = 0; k < CPUS; k++)
                    if (k != c)
                        st[k][ln] = coherence_pkg::I;
                st[c][ln]  = coherence_pkg::M;
                dat[c][ln] = store;
            end
            default: begin
                mem_img[ln] = store;
                st[c][ln]   = coherence_pkg::I;
            end
        endcase
    endtask

    task automatic start_request(input int k);
        int c;
        int ln;
        c  = steps[k].cpu;
        ln = int'(steps[k].addr[10:8]);
        case (steps[k].op)
            coherence_pkg::OP_RDX, coherence_pkg::OP_UPGR:
                for (int w = 0; w < BLOCK_WORDS; w++)
                    store_q[k][w] = $urandom;
            coherence_pkg::OP_EVICT: store_q[k] = dat[c][ln];   // the dirty copy
            default: store_q[k] = '0;
        endcase
        req[c].valid = 1'b1;
        req[c].op    = steps[k].op;
        req[c].addr  = {20'h0, steps[k].addr};
        req[c].data  = store_q[k];
    endtask

    task automatic check_completion(input int k, input int pos);
        coherence_pkg::block_t exp_load;
        int c;
        c = steps[k].cpu;
        predict_completion(c, steps[k].op, int'(steps[k].addr[10:8]), store_q[k], exp_load);
        checks++;
        assert (pos == int'(steps[k].ord)) else begin
            order_errs++;
            $display("FAILED t=%0t completion order of cpu%0d exp=%0d got=%0d",
                     $time, c, steps[k].ord, pos);
        end
        if (steps[k].op inside {coherence_pkg::OP_RD, coherence_pkg::OP_RDX}) begin
            checks += 2;
            assert (resp[c].load == exp_load) else begin
                value_errs++;
                $display("FAILED t=%0t resp[%0d].load exp=%h got=%h",
                         $time, c, exp_load, resp[c].load);
            end
            assert (resp[c].exclusive == steps[k].excl) else begin
                value_errs++;
                $display("FAILED t=%0t resp[%0d].exclusive exp=%b got=%b",
                         $time, c, steps[k].excl, resp[c].exclusive);
            end
        end
    endtask

    // model line n sits at byte address n*256, so its first L2 word index is n*64
    task automatic check_l2_image();
        logic [coherence_pkg::WORD_W-1:0] got;
        for (int l = 0; l < NLINES; l++) begin
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                got = i_coherence_top.u_l2.mem[l * 64 + w];
                checks++;
                assert (got == mem_img[l][w]) else begin
                    value_errs++;
                    $display("FAILED t=%0t u_l2.mem[%0d] exp=%h got=%h",
                             $time, l * 64 + w, mem_img[l][w], got);
                end
            end
        end
    endtask

    // issue steps first..last-1 together and collect completions in wait-low order
    task automatic run_batch(input int first, input int last);
        int pos;
        int waited;
        logic [NSTEPS-1:0] pending;
        logic [CPUS-1:0]   release_q;
        pos       = 0;
        waited    = 0;
        pending   = '0;
        release_q = '0;
        for (int k = first; k < last; k++) begin
            start_request(k);
            pending[k] = 1'b1;
        end
        while (pending != '0 && waited < TIMEOUT) begin
            @(negedge CLK);
            waited++;
            for (int c = 0; c < CPUS; c++)
                if (release_q[c])
                    req[c].valid = 1'b0;
            release_q = '0;
            for (int k = first; k < last; k++) begin
                if (pending[k] && !resp[steps[k].cpu].dwait) begin
                    check_completion(k, pos);
                    pos++;
                    pending[k]                 = 1'b0;
                    release_q[steps[k].cpu]    = 1'b1;  // held through the install edge
                end
            end
        end
        if (pending != '0) begin
            timeouts++;
            $display("timeout: step %0d onward got no wait-low within %0d cycles",
                     first, TIMEOUT);
        end
        @(negedge CLK);
        for (int c = 0; c < CPUS; c++)
            if (release_q[c])
                req[c].valid = 1'b0;
    endtask

    initial begin
        int i;
        int j;
        void'($urandom(66));
        nRST       = 1'b0;
        req        = '0;
        checks     = 0;
        value_errs = 0;
        order_errs = 0;
        timeouts   = 0;
        for (int l = 0; l < NLINES; l++) begin
            mem_img[l] = '0;
            for (int c = 0; c < CPUS; c++) begin
                st[c][l]  = coherence_pkg::I;
                dat[c][l] = '0;
            end
        end
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);

        i = 0;
        while (i < NSTEPS && timeouts == 0) begin
            j = i + 1;
            if (steps[i].grp)
                while (j < NSTEPS && steps[j].grp)
                    j++;
            run_batch(i, j);
            i = j;
        end
        check_l2_image();   // dirty transfers and evictions must have reached the L2

        $display("checks %0d, value errors %0d, order errors %0d, timeouts %0d",
                 checks, value_errs, order_errs, timeouts);
        if (value_errs + order_errs + timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/coherence_pkg.sv
rtl/l2_mem.sv
rtl/snoop_agent.sv
rtl/bus_ctrl.sv
rtl/coherence_top.sv
verif/coherence_sva.sv
verif/coherence_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module coherence_tb \
    -f verilog.f -o coherence_sim > build.log 2>&1 \
    && ./obj_dir/coherence_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation PASSED$" sim.log && echo "run.sh: pass" && exit 0 \
    || { echo "run.sh: fail"; exit 1; }
